// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  # Design
  - mem_sys_pkg.sv
  - iomem_decoder.sv
  - ram_column.sv
  - iomem_responder.sv
  - mem_subsys_top.sv
  # Verification
  - target: test
    files:
      - mem_subsys_assertions.sv
      - tb_mem_subsys.sv

// ==== iomem_decoder.sv ====
`timescale 1ns/100ps

module iomem_decoder #(
  parameter int RAM_DELAY = 16,
  parameter int RAM_WORDS = 4096
) (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  mem_sys_pkg::iomem_req_t req_i,
  output mem_sys_pkg::col_req_t   col_req_o [mem_sys_pkg::NB_COL],
  output mem_sys_pkg::region_e    region_o,
  output logic                    ram_done_o
);

  // Counter wide enough for RAM_DELAY-1
  localparam int CNT_W = $clog2(RAM_DELAY);
  // Last wait count before DEC_DONE
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RAM_DELAY - 1);

  mem_sys_pkg::word_index_t ram_index;
  logic                     in_ram_window;
  logic                     is_write;

  mem_sys_pkg::dec_state_e  state_q;
  mem_sys_pkg::dec_state_e  state_d;
  logic [CNT_W-1:0]         cnt_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Word index inside the RAM window
  assign ram_index = req_i.addr[19:2];

  // Base compare under the mask
  assign in_ram_window =
    (req_i.addr & ~mem_sys_pkg::RAM_MASK) == mem_sys_pkg::RAM_BASE;

  // Any set strobe bit makes it a write
  assign is_write = |req_i.wstrb;

  always_comb begin
    // Indices past the built depth fall to unmapped
    if (in_ram_window && (32'(ram_index) < RAM_WORDS)) begin
      region_o = mem_sys_pkg::REGION_RAM;
    end else if (req_i.addr == mem_sys_pkg::TIMER_LO_ADDR) begin
      region_o = mem_sys_pkg::REGION_TIMER_LO;
    end else if (req_i.addr == mem_sys_pkg::TIMER_HI_ADDR) begin
      region_o = mem_sys_pkg::REGION_TIMER_HI;
    end else begin
      region_o = mem_sys_pkg::REGION_NONE;
    end
  end

  ////////////////////////////////////////
  // RAM delay FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_sys_pkg::DEC_IDLE: begin
        // Accept on first sampled RAM request
        if (req_i.valid && (region_o == mem_sys_pkg::REGION_RAM)) begin
          state_d = mem_sys_pkg::DEC_WAIT;
        end
      end
      mem_sys_pkg::DEC_WAIT: begin
        // DEC_DONE entered RAM_DELAY edges after acceptance
        if (cnt_q == CNT_LAST) begin
          state_d = mem_sys_pkg::DEC_DONE;
        end
      end
      mem_sys_pkg::DEC_DONE: begin
        // Completion edge, always back to idle
        state_d = mem_sys_pkg::DEC_IDLE;
      end
      default: begin
        state_d = mem_sys_pkg::DEC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q <= mem_sys_pkg::DEC_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      // Counts only while waiting
      if (state_q == mem_sys_pkg::DEC_WAIT) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  // One-cycle pulse, ready cycle of the RAM access
  assign ram_done_o = (state_q == mem_sys_pkg::DEC_DONE);

  ////////////////////////////////////////
  // Per-lane requests
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < mem_sys_pkg::NB_COL; i++) begin
      // Read held across the wait, data settles early
      col_req_o[i].rd_en = (state_q == mem_sys_pkg::DEC_WAIT) && !is_write;
      // Write lands on the completion edge, strobed lanes only
      col_req_o[i].wr_en = ram_done_o && is_write && req_i.wstrb[i];
      col_req_o[i].index = ram_index;
      col_req_o[i].wdata = req_i.wdata[8*i +: 8];
    end
  end

endmodule

// ==== iomem_responder.sv ====
`timescale 1ns/100ps

module iomem_responder (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  mem_sys_pkg::iomem_req_t req_i,
  input  mem_sys_pkg::region_e    region_i,
  input  logic                    ram_done_i,
  input  mem_sys_pkg::byte_t      col_rdata_i [mem_sys_pkg::NB_COL],
  output logic                    ready_o,
  output mem_sys_pkg::word_t      rdata_o
);

  // Free-running cycle count since reset release
  logic [63:0]        timer_q;
  // RAM word joined from the lanes
  mem_sys_pkg::word_t ram_word;

  ////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else begin
      // Wraps after 2^64 edges
      timer_q <= timer_q + 64'd1;
    end
  end

  ////////////////////////////////////////
  // RAM read data
  ////////////////////////////////////////

  always_comb begin
    ram_word = '0;
    // Lane i carries byte i of the word
    for (int i = 0; i < mem_sys_pkg::NB_COL; i++) begin
      ram_word[8*i +: 8] = col_rdata_i[i];
    end
  end

  ////////////////////////////////////////
  // Ready and read mux
  ////////////////////////////////////////

  always_comb begin
    case (region_i)
      mem_sys_pkg::REGION_RAM: begin
        // Ready only in the DEC_DONE cycle
        ready_o = ram_done_i;
        rdata_o = ram_word;
      end
      mem_sys_pkg::REGION_TIMER_LO: begin
        // Zero wait
        ready_o = req_i.valid;
        rdata_o = timer_q[31:0];
      end
      mem_sys_pkg::REGION_TIMER_HI: begin
        ready_o = req_i.valid;
        rdata_o = timer_q[63:32];
      end
      default: begin
        // Unmapped, completes at once and reads zero
        ready_o = req_i.valid;
        rdata_o = '0;
      end
    endcase
  end

endmodule

// ==== list.f ====
mem_sys_pkg.sv
iomem_decoder.sv
ram_column.sv
iomem_responder.sv
mem_subsys_top.sv
mem_subsys_assertions.sv
tb_mem_subsys.sv

// ==== mem_subsys_assertions.sv ====
`timescale 1ns/100ps

module mem_subsys_assertions #(
  parameter int RAM_DELAY = 16
) (
  input logic                    clk_i,
  input logic                    rst_n,
  input mem_sys_pkg::iomem_req_t req_i,
  input mem_sys_pkg::region_e    region_i,
  input logic                    ready_i
);

  // Number of assertion failures
  int unsigned fail_cnt = 0;

  // No completion without a request
  a_ready_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_n)
    ready_i |-> req_i.valid)
    else begin
      fail_cnt++;
      $error("ready high without valid");
    end

  // First sample of a RAM request after idle or a completed transfer
  a_ram_delay : assert property (@(posedge clk_i) disable iff (!rst_n)
    (req_i.valid && (region_i == mem_sys_pkg::REGION_RAM) &&
     (!$past(req_i.valid) || $past(ready_i)))
    |=> !ready_i [*RAM_DELAY] ##1 ready_i)
    else begin
      fail_cnt++;
      $error("RAM ready not after the programmed delay");
    end

  // Requester holds the request while stalled
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n)
    (req_i.valid && !ready_i) |=> $stable(req_i))
    else begin
      fail_cnt++;
      $error("request changed while waiting for ready");
    end

endmodule

bind mem_subsys_top mem_subsys_assertions #(
  .RAM_DELAY (RAM_DELAY)
) u_assertions (
  .clk_i    (clk_i),
  .rst_n    (rst_n),
  .req_i    (req_i),
  .region_i (region),
  .ready_i  (ready_o)
);

// ==== mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top #(
  parameter int RAM_DELAY = 16,
  parameter int RAM_WORDS = 4096
) (
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  mem_sys_pkg::iomem_req_t req_i,
  output logic                    ready_o,
  output mem_sys_pkg::word_t      rdata_o
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Decoder to lanes
  mem_sys_pkg::col_req_t col_req   [mem_sys_pkg::NB_COL];
  // Lanes to responder
  mem_sys_pkg::byte_t    col_rdata [mem_sys_pkg::NB_COL];
  // Decoder to responder
  mem_sys_pkg::region_e  region;
  logic                  ram_done;

  // Address decode and RAM delay
  iomem_decoder #(
    .RAM_DELAY (RAM_DELAY),
    .RAM_WORDS (RAM_WORDS)
  ) u_decoder (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .col_req_o  (col_req),
    .region_o   (region),
    .ram_done_o (ram_done)
  );

  // One column per byte lane
  for (genvar gi = 0; gi < mem_sys_pkg::NB_COL; gi++) begin : g_col
    ram_column #(
      .RAM_WORDS (RAM_WORDS)
    ) u_column (
      .clk_i     (clk_i),
      .col_req_i (col_req[gi]),
      .rdata_o   (col_rdata[gi])
    );
  end

  // Timer, read mux and ready
  iomem_responder u_responder (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .region_i    (region),
    .ram_done_i  (ram_done),
    .col_rdata_i (col_rdata),
    .ready_o     (ready_o),
    .rdata_o     (rdata_o)
  );

endmodule

// ==== mem_sys_pkg.sv ====
package mem_sys_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Bus data word
  typedef logic [31:0] word_t;
  // Byte address on the bus
  typedef logic [31:0] addr_t;
  // Contents of one RAM byte lane
  typedef logic [7:0]  byte_t;
  // One strobe bit per byte lane
  typedef logic [3:0]  strb_t;
  // RAM word index, address bits 19 down to 2
  typedef logic [17:0] word_index_t;

  // Byte lanes in main RAM
  parameter int NB_COL = 4;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////

  parameter addr_t RAM_BASE      = 32'h4000_0000;
  parameter addr_t RAM_MASK      = 32'h000F_FFFF;
  parameter addr_t TIMER_LO_ADDR = 32'h3000_0000;
  parameter addr_t TIMER_HI_ADDR = 32'h3000_0004;

  // Request from the requester, zero wstrb means read
  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } iomem_req_t;

  // Request to a single byte lane
  typedef struct packed {
    logic        rd_en;
    logic        wr_en;
    word_index_t index;
    byte_t       wdata;
  } col_req_t;

  // Decoded target of the current address
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_RAM,
    REGION_TIMER_LO,
    REGION_TIMER_HI
  } region_e;

  // RAM delay FSM
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_WAIT,
    DEC_DONE
  } dec_state_e;

endpackage

// ==== ram_column.sv ====
`timescale 1ns/100ps

module ram_column #(
  parameter int RAM_WORDS = 4096
) (
  input  logic                  clk_i,
  input  mem_sys_pkg::col_req_t col_req_i,
  output mem_sys_pkg::byte_t    rdata_o
);

  // Index bits actually used by the array
  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One byte lane of main RAM
  mem_sys_pkg::byte_t mem_q [RAM_WORDS];

  logic [AW-1:0] word_addr;

  // Upper index bits are out of range, decoder filters them
  assign word_addr = col_req_i.index[AW-1:0];

  ////////////////////////////////////////
  // Access
  ////////////////////////////////////////

  // Strobed byte write
  always_ff @(posedge clk_i) begin
    if (col_req_i.wr_en) begin
      mem_q[word_addr] <= col_req_i.wdata;
    end
  end

  // Registered read, holds value when idle
  always_ff @(posedge clk_i) begin
    if (col_req_i.rd_en) begin
      rdata_o <= mem_q[word_addr];
    end
  end

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys;

  localparam int RAM_DELAY = 4;
  localparam int RAM_WORDS = 256;
  // Bus accesses per test add up to 32 + 31 + 3 + 8 + 16
  localparam int N_ACCESS  = 90;
  localparam int TIMEOUT   = N_ACCESS * (RAM_DELAY + 3) + 200;
  // Edges from first sample to completion
  localparam int RAM_LAT   = RAM_DELAY + 1;

  logic                    clk_i;
  logic                    rst_n;
  mem_sys_pkg::iomem_req_t req;
  logic                    ready;
  mem_sys_pkg::word_t      rdata;

  // Rising edges since reset release
  int edge_cnt = 0;
  int seed;
  // Expected RAM contents, keyed by word index
  mem_sys_pkg::word_t ref_mem [mem_sys_pkg::word_index_t];

  mem_subsys_top #(
    .RAM_DELAY (RAM_DELAY),
    .RAM_WORDS (RAM_WORDS)
  ) DUT (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .req_i   (req),
    .ready_o (ready),
    .rdata_o (rdata)
  );

  always #20 clk_i = ~clk_i;

  // Edge count drives the run limit
  always @(posedge clk_i) begin
    if (rst_n) begin
      edge_cnt <= edge_cnt + 1;
      if (edge_cnt >= TIMEOUT) begin
        $display("Run did not finish within %0d cycles, bus looks stuck", TIMEOUT);
        stop_run();
      end
      if (DUT.u_assertions.fail_cnt != 0) begin
        $display("A bus protocol assertion failed, see the error above");
        stop_run();
      end
    end
  end

  ////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string what, input mem_sys_pkg::word_t exp,
                            input mem_sys_pkg::word_t got);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s expected %08h got %08h", $time, what, exp, got);
      stop_run();
    end
  endtask

  task automatic check_ready_latency(input string what, input int exp, input int got);
    if (got != exp) begin
      $display("ERROR at %0t ns: %s latency expected %0d got %0d", $time, what, exp, got);
      stop_run();
    end
  endtask

  function automatic mem_sys_pkg::addr_t ram_addr(input mem_sys_pkg::word_index_t idx);
    return mem_sys_pkg::RAM_BASE | (mem_sys_pkg::addr_t'(idx) << 2);
  endfunction

  // Reference byte-strobe update
  function automatic mem_sys_pkg::word_t merge_bytes(input mem_sys_pkg::word_t old_w,
                                                     input mem_sys_pkg::word_t new_w,
                                                     input mem_sys_pkg::strb_t strb);
    mem_sys_pkg::word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic mem_sys_pkg::word_index_t rand_index();
    return mem_sys_pkg::word_index_t'($unsigned($random(seed)) % RAM_WORDS);
  endfunction

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  // Starts just after a rising edge and returns at the completion edge
  task automatic run_transfer(input mem_sys_pkg::addr_t addr, input mem_sys_pkg::word_t wdata,
                              input mem_sys_pkg::strb_t wstrb, output mem_sys_pkg::word_t rd,
                              output int done_edge, output int lat);
    mem_sys_pkg::iomem_req_t r;
    int req_edge;
    r.valid = 1'b1;
    r.addr  = addr;
    r.wdata = wdata;
    r.wstrb = wstrb;
    req <= r;
    // Sample mid-cycle so the coming edge is the first sample
    @(negedge clk_i);
    req_edge = edge_cnt + 1;
    while (!ready) begin
      @(negedge clk_i);
    end
    rd        = rdata;
    done_edge = edge_cnt + 1;
    lat       = done_edge - req_edge;
    @(posedge clk_i);
  endtask

  task automatic bus_write(input mem_sys_pkg::addr_t addr, input mem_sys_pkg::word_t wdata,
                           input mem_sys_pkg::strb_t wstrb, output int done_edge,
                           output int lat);
    mem_sys_pkg::word_t unused;
    run_transfer(addr, wdata, wstrb, unused, done_edge, lat);
  endtask

  task automatic bus_read(input mem_sys_pkg::addr_t addr, output mem_sys_pkg::word_t rd,
                          output int done_edge, output int lat);
    run_transfer(addr, '0, 4'h0, rd, done_edge, lat);
  endtask

  // Drop valid for one cycle
  task automatic idle_cycle();
    req <= '0;
    @(posedge clk_i);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic full_word_rw();
    mem_sys_pkg::word_index_t idx [16];
    mem_sys_pkg::word_t       d;
    int done;
    int lat;
    for (int i = 0; i < 16; i++) begin
      idx[i] = rand_index();
      d      = $random(seed);
      bus_write(ram_addr(idx[i]), d, 4'hf, done, lat);
      ref_mem[idx[i]] = d;
      check_ready_latency("full write", RAM_LAT, lat);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(ram_addr(idx[i]), d, done, lat);
      check_word("full read", ref_mem[idx[i]], d);
      check_ready_latency("full read", RAM_LAT, lat);
    end
    idle_cycle();
  endtask

  task automatic strobed_writes();
    mem_sys_pkg::word_index_t idx;
    mem_sys_pkg::word_t       d;
    int done;
    int lat;
    idx = rand_index();
    d   = $random(seed);
    bus_write(ram_addr(idx), d, 4'hf, done, lat);
    ref_mem[idx] = d;
    // Every nonzero strobe pattern on one word
    for (int s = 1; s < 16; s++) begin
      d = $random(seed);
      bus_write(ram_addr(idx), d, mem_sys_pkg::strb_t'(s), done, lat);
      ref_mem[idx] = merge_bytes(ref_mem[idx], d, mem_sys_pkg::strb_t'(s));
      bus_read(ram_addr(idx), d, done, lat);
      check_word("strobed read", ref_mem[idx], d);
    end
    idle_cycle();
  endtask

  task automatic timer_reads();
    mem_sys_pkg::word_t v1;
    mem_sys_pkg::word_t v2;
    int done1;
    int done2;
    int lat;
    int gap;
    bus_read(mem_sys_pkg::TIMER_LO_ADDR, v1, done1, lat);
    check_ready_latency("timer low", 0, lat);
    // Count seen during the cycle before the completion edge
    check_word("timer low value", mem_sys_pkg::word_t'(done1 - 1), v1);
    gap = ($unsigned($random(seed)) % 16) + 1;
    repeat (gap) idle_cycle();
    bus_read(mem_sys_pkg::TIMER_LO_ADDR, v2, done2, lat);
    check_word("timer low step", mem_sys_pkg::word_t'(done2 - done1), v2 - v1);
    bus_read(mem_sys_pkg::TIMER_HI_ADDR, v2, done2, lat);
    check_word("timer high", '0, v2);
    check_ready_latency("timer high", 0, lat);
    idle_cycle();
  endtask

  task automatic unmapped_access();
    mem_sys_pkg::addr_t holes [4];
    mem_sys_pkg::word_t d;
    int done;
    int lat;
    // Index past the built depth would alias word 0
    holes[0] = mem_sys_pkg::RAM_BASE + 32'(RAM_WORDS * 4);
    holes[1] = 32'h400F_FFFC;
    holes[2] = 32'h3000_0008;
    holes[3] = 32'h2000_0000;
    d = $random(seed);
    bus_write(ram_addr('0), d, 4'hf, done, lat);
    ref_mem[0] = d;
    for (int i = 0; i < 4; i++) begin
      bus_read(holes[i], d, done, lat);
      check_word("unmapped read", '0, d);
      check_ready_latency("unmapped read", 0, lat);
    end
    bus_write(holes[0], ~ref_mem[0], 4'hf, done, lat);
    check_ready_latency("unmapped write", 0, lat);
    bus_write(holes[1], 32'hdead_beef, 4'hf, done, lat);
    check_ready_latency("unmapped write", 0, lat);
    bus_read(ram_addr('0), d, done, lat);
    check_word("RAM after unmapped write", ref_mem[0], d);
    idle_cycle();
  endtask

  // Valid held high across all accesses
  task automatic alternating_accesses();
    mem_sys_pkg::word_index_t idx;
    mem_sys_pkg::word_t       d;
    int done;
    int lat;
    for (int i = 0; i < 4; i++) begin
      idx = rand_index();
      d   = $random(seed);
      bus_write(ram_addr(idx), d, 4'hf, done, lat);
      ref_mem[idx] = d;
      check_ready_latency("b2b write", RAM_LAT, lat);
      bus_read(mem_sys_pkg::TIMER_LO_ADDR, d, done, lat);
      check_word("b2b timer", mem_sys_pkg::word_t'(done - 1), d);
      check_ready_latency("b2b timer", 0, lat);
      bus_read(ram_addr(idx), d, done, lat);
      check_word("b2b read", ref_mem[idx], d);
      check_ready_latency("b2b read", RAM_LAT, lat);
      bus_read(mem_sys_pkg::TIMER_LO_ADDR, d, done, lat);
      check_word("b2b timer", mem_sys_pkg::word_t'(done - 1), d);
      check_ready_latency("b2b timer", 0, lat);
    end
    idle_cycle();
  endtask

  initial begin
    seed  = 32'hac32;
    clk_i = 1'b0;
    rst_n = 1'b0;
    req   = '0;
    repeat (8) @(posedge clk_i);
    rst_n <= 1'b1;
    @(posedge clk_i);
    full_word_rw();
    strobed_writes();
    timer_reads();
    unmapped_access();
    alternating_accesses();
    // Let the last assertion evaluations settle
    @(negedge clk_i);
    if (DUT.u_assertions.fail_cnt != 0) begin
      $display("A bus protocol assertion failed, see the error above");
      stop_run();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
